/* common/fpu_pkg.sv */
// fpu_pkg
// shared widths, word types, opcodes and compare flag layout for the
// floating-point side unit

package fpu_pkg;

  // operand word and single-precision half
  localparam int WORD_W = 64;
  localparam int HALF_W = 32;

  // ieee double field widths
  localparam int EXP_W  = 11;
  localparam int MANT_W = 52;

  typedef logic [WORD_W-1:0] fp_word_t;
  typedef logic [HALF_W-1:0] half_t;

  // permute ops first, compares after
  typedef enum logic [3:0] {
    op_copy_a    = 4'd0,
    op_copy_b    = 4'd1,
    op_swap      = 4'd2,
    op_dup_lo    = 4'd3,
    op_merge     = 4'd4,
    op_cmp_eq    = 4'd5,
    op_cmp_lt    = 4'd6,
    op_cmp_le    = 4'd7,
    op_cmp_unord = 4'd8
  } fpu_op_e;

  // compare flags
  typedef logic [3:0] cmp_flags_t;

  localparam int FLAG_EQ = 0;
  localparam int FLAG_LT = 1;
  localparam int FLAG_GT = 2;
  localparam int FLAG_UN = 3;

  // issue register occupancy
  typedef enum logic [1:0] {
    st_empty = 2'd0,
    st_full  = 2'd1
  } issue_state_e;

endpackage

/* fpu_execute/fp_compare.sv */
// fp_compare
// ieee double compare, NaN classification and invalid detection

`timescale 1ns/100ps

module fp_compare import fpu_pkg::*; (
  input  fp_word_t   a,
  input  fp_word_t   b,
  input  logic       ordered,
  output cmp_flags_t flags,
  output logic       invalid
);

  logic a_sign;
  logic b_sign;
  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic both_zero;
  logic mag_lt;
  logic mag_eq;
  logic lt;
  logic eq;

  assign a_sign = a[WORD_W-1];
  assign b_sign = b[WORD_W-1];

  // exponent all ones with a nonzero mantissa
  assign a_nan = (&a[WORD_W-2:MANT_W]) & (|a[MANT_W-1:0]);
  assign b_nan = (&b[WORD_W-2:MANT_W]) & (|b[MANT_W-1:0]);

  // quiet bit clear means signaling
  assign a_snan = a_nan & ~a[MANT_W-1];
  assign b_snan = b_nan & ~b[MANT_W-1];

  // +0 and -0 compare equal
  assign both_zero = (a[WORD_W-2:0] == '0) && (b[WORD_W-2:0] == '0);

  assign mag_lt = a[WORD_W-2:0] < b[WORD_W-2:0];
  assign mag_eq = a[WORD_W-2:0] == b[WORD_W-2:0];

  always_comb begin
    if (both_zero) begin
      eq = 1'b1;
      lt = 1'b0;
    end else if (a_sign != b_sign) begin
      eq = 1'b0;
      lt = a_sign;
    end else begin
      eq = mag_eq;
      // negative values order by reversed magnitude
      lt = a_sign ? (~mag_lt & ~mag_eq) : mag_lt;
    end
  end

  always_comb begin
    flags = '0;
    if (a_nan || b_nan) begin
      flags[FLAG_UN] = 1'b1;
    end else begin
      flags[FLAG_EQ] = eq;
      flags[FLAG_LT] = lt;
      flags[FLAG_GT] = ~eq & ~lt;
    end
  end

  assign invalid = a_snan | b_snan | (ordered & (a_nan | b_nan));

endmodule

/* fpu_execute/fpu_execute.sv */
// fpu_execute
// permute datapath and double compare, result select, invalid trap
// masking and the output register

`timescale 1ns/100ps

module fpu_execute import fpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  logic       opnd_valid,
  input  fpu_op_e    stage1_op,
  input  fp_word_t   opnd_a,
  input  fp_word_t   opnd_b,
  input  logic       trap_invalid_en,
  input  logic       out_ready,
  output logic       out_valid,
  output fp_word_t   out_result,
  output cmp_flags_t out_flags,
  output logic       out_trap,
  output logic       out_invalid
);

  fpu_op_e    stage2_op;
  half_t      a_hi;
  half_t      a_lo;
  half_t      b_lo;
  logic       is_cmp;
  logic       ordered;
  logic       relation;
  cmp_flags_t cmp_flags;
  logic       cmp_invalid;
  fp_word_t   result;
  cmp_flags_t flags;
  logic       invalid;

  // op travels next to the operands
  always_ff @(posedge clk) begin
    if (advance) begin
      stage2_op <= stage1_op;
    end
  end

  assign a_hi = opnd_a[WORD_W-1:HALF_W];
  assign a_lo = opnd_a[HALF_W-1:0];
  assign b_lo = opnd_b[HALF_W-1:0];

  assign is_cmp  = (stage2_op == op_cmp_eq) || (stage2_op == op_cmp_lt) ||
                   (stage2_op == op_cmp_le) || (stage2_op == op_cmp_unord);
  assign ordered = (stage2_op == op_cmp_lt) || (stage2_op == op_cmp_le);

  fp_compare u_compare (
    .a       (opnd_a),
    .b       (opnd_b),
    .ordered (ordered),
    .flags   (cmp_flags),
    .invalid (cmp_invalid)
  );

  // tested relation per compare op
  always_comb begin
    case (stage2_op)
      op_cmp_eq: relation = cmp_flags[FLAG_EQ];
      op_cmp_lt: relation = cmp_flags[FLAG_LT];
      op_cmp_le: relation = cmp_flags[FLAG_EQ] | cmp_flags[FLAG_LT];
      default:   relation = cmp_flags[FLAG_UN];
    endcase
  end

  always_comb begin
    case (stage2_op)
      op_copy_a: result = opnd_a;
      op_copy_b: result = opnd_b;
      op_swap:   result = {a_lo, a_hi};
      op_dup_lo: result = {a_lo, a_lo};
      op_merge:  result = {a_hi, b_lo};
      default:   result = {WORD_W{relation}};
    endcase
  end

  // permutes raise nothing
  assign flags   = is_cmp ? cmp_flags : '0;
  assign invalid = is_cmp & cmp_invalid;

  // load on advance, drop once the sink takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= advance ? opnd_valid : (out_valid & ~out_ready);
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_result  <= result;
      out_flags   <= flags;
      out_invalid <= invalid;
      out_trap    <= invalid & trap_invalid_en;
    end
  end

endmodule

/* verilog/operand_bypass.sv */
// operand_bypass
// picks one operand from the issued word or a result bypass bus,
// current or one cycle old, and holds it in the stage 2 register

`timescale 1ns/100ps

module operand_bypass import fpu_pkg::*; #(
  parameter int NUM_FWD = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          advance,
  input  logic                          stage1_valid,
  input  fp_word_t                      issued,
  input  logic [$clog2(NUM_FWD+1)-1:0]  src,
  input  logic                          late,
  input  fp_word_t [NUM_FWD-1:0]        fwd_data,
  output fp_word_t                      opnd,
  output logic                          opnd_valid
);

  localparam int SEL_W = $clog2(NUM_FWD + 1);

  fp_word_t [NUM_FWD-1:0] fwd_prev;
  fp_word_t               sel_word;

  // bus copy runs every edge, stall or not
  always_ff @(posedge clk) begin
    fwd_prev <= fwd_data;
  end

  // code 0 is the issued value, code k is bus k-1
  always_comb begin
    sel_word = issued;
    for (int k = 0; k < NUM_FWD; k++) begin
      if (src == SEL_W'(k + 1)) begin
        sel_word = late ? fwd_prev[k] : fwd_data[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      opnd_valid <= 1'b0;
    end else if (advance) begin
      opnd_valid <= stage1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      opnd <= sel_word;
    end
  end

endmodule

/* verilog/fpu_issue.sv */
// fpu_issue
// input handshake and issue register, and the single pipeline advance
// signal shared by all stages

`timescale 1ns/100ps

module fpu_issue import fpu_pkg::*; #(
  parameter int NUM_FWD = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  fpu_op_e                       in_op,
  input  fp_word_t                      in_a,
  input  fp_word_t                      in_b,
  input  logic [$clog2(NUM_FWD+1)-1:0]  in_src_a,
  input  logic [$clog2(NUM_FWD+1)-1:0]  in_src_b,
  input  logic                          in_late_a,
  input  logic                          in_late_b,
  input  logic                          out_valid,
  input  logic                          out_ready,
  output logic                          in_ready,
  output logic                          advance,
  output logic                          stage1_valid,
  output fpu_op_e                       stage1_op,
  output fp_word_t                      stage1_a,
  output fp_word_t                      stage1_b,
  output logic [$clog2(NUM_FWD+1)-1:0]  stage1_src_a,
  output logic [$clog2(NUM_FWD+1)-1:0]  stage1_src_b,
  output logic                          stage1_late_a,
  output logic                          stage1_late_b
);

  localparam int SEL_W = $clog2(NUM_FWD + 1);

  issue_state_e state;
  logic         load;

  // the whole pipe stalls only when a result waits at the output
  assign advance  = ~out_valid | out_ready;
  assign in_ready = advance;
  assign load     = advance & in_valid;

  assign stage1_valid = (state == st_full);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_empty;
    end else if (advance) begin
      // item moves on, refill only on a new transfer
      state <= in_valid ? st_full : st_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      stage1_op     <= in_op;
      stage1_a      <= in_a;
      stage1_b      <= in_b;
      stage1_src_a  <= in_src_a[SEL_W-1:0];
      stage1_src_b  <= in_src_b[SEL_W-1:0];
      stage1_late_a <= in_late_a;
      stage1_late_b <= in_late_b;
    end
  end

endmodule

/* verilog/fpu_top.sv */
// fpu_top
// floating-point side unit: issue register, two operand bypass stages
// and the permute / double compare execute stage

`timescale 1ns/100ps

module fpu_top import fpu_pkg::*; #(
  parameter int NUM_FWD = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  fpu_op_e                           in_op,
  input  fp_word_t                          in_a,
  input  fp_word_t                          in_b,
  input  logic [$clog2(NUM_FWD+1)-1:0]      in_src_a,
  input  logic [$clog2(NUM_FWD+1)-1:0]      in_src_b,
  input  logic                              in_late_a,
  input  logic                              in_late_b,
  input  fp_word_t [NUM_FWD-1:0]            fwd_data,
  input  logic                              trap_invalid_en,
  output logic                              out_valid,
  input  logic                              out_ready,
  output fp_word_t                          out_result,
  output cmp_flags_t                        out_flags,
  output logic                              out_trap,
  output logic                              out_invalid
);

  localparam int SEL_W = $clog2(NUM_FWD + 1);

  logic             advance;
  logic             stage1_valid;
  fpu_op_e          stage1_op;
  fp_word_t         stage1_a;
  fp_word_t         stage1_b;
  logic [SEL_W-1:0] stage1_src_a;
  logic [SEL_W-1:0] stage1_src_b;
  logic             stage1_late_a;
  logic             stage1_late_b;
  fp_word_t [1:0]   opnd;
  logic [1:0]       opnd_valid_vec;

  fpu_issue #(.NUM_FWD(NUM_FWD)) u_issue (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_a          (in_a),
    .in_b          (in_b),
    .in_src_a      (in_src_a),
    .in_src_b      (in_src_b),
    .in_late_a     (in_late_a),
    .in_late_b     (in_late_b),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .in_ready      (in_ready),
    .advance       (advance),
    .stage1_valid  (stage1_valid),
    .stage1_op     (stage1_op),
    .stage1_a      (stage1_a),
    .stage1_b      (stage1_b),
    .stage1_src_a  (stage1_src_a),
    .stage1_src_b  (stage1_src_b),
    .stage1_late_a (stage1_late_a),
    .stage1_late_b (stage1_late_b)
  );

  // index 0 is operand a, index 1 is operand b
  for (genvar i = 0; i < 2; i++) begin : g_opnd
    operand_bypass #(.NUM_FWD(NUM_FWD)) u_bypass (
      .clk          (clk),
      .rst          (rst),
      .advance      (advance),
      .stage1_valid (stage1_valid),
      .issued       ((i == 0) ? stage1_a : stage1_b),
      .src          ((i == 0) ? stage1_src_a : stage1_src_b),
      .late         ((i == 0) ? stage1_late_a : stage1_late_b),
      .fwd_data     (fwd_data),
      .opnd         (opnd[i]),
      .opnd_valid   (opnd_valid_vec[i])
    );
  end

  // both bypass valids track stage1_valid, a's copy is used
  fpu_execute u_execute (
    .clk             (clk),
    .rst             (rst),
    .advance         (advance),
    .opnd_valid      (opnd_valid_vec[0]),
    .stage1_op       (stage1_op),
    .opnd_a          (opnd[0]),
    .opnd_b          (opnd[1]),
    .trap_invalid_en (trap_invalid_en),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_result      (out_result),
    .out_flags       (out_flags),
    .out_trap        (out_trap),
    .out_invalid     (out_invalid)
  );

endmodule

/* tb/tb_fpu.sv */
// tb_fpu
// random and directed testbench for the floating-point side unit, with a
// cycle model of the three-stage pipeline and its handshakes

`timescale 1ns/100ps

module tb_fpu import fpu_pkg::*; ();

  localparam int NUM_FWD   = 4;
  localparam int SEL_W     = $clog2(NUM_FWD + 1);
  localparam int OPS       = 200;
  localparam int NUM_TESTS = 5;
  localparam int RST_CYC   = 16;
  localparam int MAX_CYC   = NUM_TESTS * OPS * 20 + RST_CYC;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   in_valid;
  logic                   in_ready;
  fpu_op_e                in_op;
  fp_word_t               in_a;
  fp_word_t               in_b;
  logic [SEL_W-1:0]       in_src_a;
  logic [SEL_W-1:0]       in_src_b;
  logic                   in_late_a;
  logic                   in_late_b;
  fp_word_t [NUM_FWD-1:0] fwd_data = '0;
  logic                   trap_invalid_en = 1'b0;
  logic                   out_valid;
  logic                   out_ready = 1'b1;
  fp_word_t               out_result;
  cmp_flags_t             out_flags;
  logic                   out_trap;
  logic                   out_invalid;

  integer seed = 32'hc31;
  int     errors = 0;
  int     cycle = 0;
  logic   ready_random = 1'b0;

  // model state, one set of registers per pipeline stage
  logic                   s1_valid, s2_valid, m_out_valid, hold_seen;
  fpu_op_e                s1_op, s2_op;
  fp_word_t               s1_a, s1_b, s2_a, s2_b;
  logic [SEL_W-1:0]       s1_src_a, s1_src_b;
  logic                   s1_late_a, s1_late_b;
  int                     s1_cycle, s2_cycle;
  fp_word_t [NUM_FWD-1:0] m_prev;
  // entry is {accept cycle, trap, invalid, flags, result}
  logic [101:0]           exp_q[$];
  logic [101:0]           exp_e;
  logic [69:0]            held;

  fpu_top #(.NUM_FWD(NUM_FWD)) DUT (.*);

  always #5 clk = ~clk;

  // buses, trap enable and sink readiness move every cycle
  always @(posedge clk) begin
    for (int k = 0; k < NUM_FWD; k++) begin
      fwd_data[k] <= {$random(seed), $random(seed)};
    end
    trap_invalid_en <= 1'($random(seed));
    out_ready <= ready_random ? ({$random(seed)} % 3 != 0) : 1'b1;
  end

  function automatic fp_word_t special_value(int idx);
    case (idx)
      0:       return 64'h0000_0000_0000_0000;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'h7ff0_0000_0000_0000;
      3:       return 64'hfff0_0000_0000_0000;
      4:       return 64'h7ff8_0000_0000_0000;
      5:       return 64'h7ff0_0000_0000_0001;
      6:       return 64'hfff8_0000_0000_0123;
      7:       return 64'h3ff0_0000_0000_0000;
      8:       return 64'hbff0_0000_0000_0000;
      9:       return 64'h4000_0000_0000_0000;
      10:      return 64'h0000_0000_0000_0001;
      default: return 64'h7fef_ffff_ffff_ffff;
    endcase
  endfunction

  function automatic fp_word_t pick_operand(fp_word_t issued, logic [SEL_W-1:0] src,
      logic late, fp_word_t [NUM_FWD-1:0] cur, fp_word_t [NUM_FWD-1:0] prev);
    if (src == 0) begin
      return issued;
    end
    return late ? prev[src-1] : cur[src-1];
  endfunction

  // expected {invalid, flags, result}, ordering taken from real arithmetic
  function automatic logic [68:0] expected_exec(fpu_op_e op, fp_word_t a, fp_word_t b);
    logic       a_nan, b_nan, a_snan, b_snan, rel, inv;
    cmp_flags_t fl;
    fp_word_t   res;
    a_nan  = (a[62:52] == 11'h7ff) && (a[51:0] != 52'd0);
    b_nan  = (b[62:52] == 11'h7ff) && (b[51:0] != 52'd0);
    a_snan = a_nan && !a[51];
    b_snan = b_nan && !b[51];
    fl = 4'b1000;
    if (!a_nan && !b_nan) begin
      fl[0] = ($bitstoreal(a) == $bitstoreal(b));
      fl[1] = ($bitstoreal(a) < $bitstoreal(b));
      fl[2] = ($bitstoreal(a) > $bitstoreal(b));
      fl[3] = 1'b0;
    end
    case (op)
      op_cmp_eq: rel = fl[0];
      op_cmp_lt: rel = fl[1];
      op_cmp_le: rel = fl[0] | fl[1];
      default:   rel = fl[3];
    endcase
    inv = a_snan || b_snan || ((op == op_cmp_lt || op == op_cmp_le) && (a_nan || b_nan));
    case (op)
      op_copy_a: res = a;
      op_copy_b: res = b;
      op_swap:   res = {a[31:0], a[63:32]};
      op_dup_lo: res = {a[31:0], a[31:0]};
      op_merge:  res = {a[63:32], b[31:0]};
      default:   res = rel ? '1 : '0;
    endcase
    if (op < op_cmp_eq) begin
      return {1'b0, 4'b0000, res};
    end
    return {inv, fl, res};
  endfunction

  always @(posedge clk) begin
    logic        adv;
    logic [68:0] m;
    logic [69:0] got;
    adv = !m_out_valid || out_ready;
    got = {out_trap, out_invalid, out_flags, out_result};
    cycle++;
    if (rst) begin
      s1_valid = 1'b0;
      s2_valid = 1'b0;
      m_out_valid = 1'b0;
      hold_seen = 1'b0;
    end else begin
      if (in_ready !== adv || out_valid !== m_out_valid) begin
        $display("Error at %0t: in_ready %b out_valid %b, expected %b %b", $time,
                 in_ready, out_valid, adv, m_out_valid);
        errors++;
      end
      if (hold_seen && got !== held) begin
        $display("Error at %0t: outputs changed while stalled", $time);
        errors++;
      end
      hold_seen = out_valid && !out_ready;
      held = got;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: result %h came out with no op pending", $time, out_result);
          errors++;
        end else begin
          exp_e = exp_q.pop_front();
          if (got !== exp_e[69:0]) begin
            $display("Error at %0t: got trap/inv/flags/result %h, expected %h", $time,
                     got, exp_e[69:0]);
            errors++;
          end
          if (!ready_random && cycle != int'(exp_e[101:70]) + 3) begin
            $display("Error at %0t: result accepted at cycle %0d left at cycle %0d",
                     $time, exp_e[101:70], cycle);
            errors++;
          end
        end
      end
      if (adv) begin
        if (s2_valid) begin
          m = expected_exec(s2_op, s2_a, s2_b);
          exp_q.push_back({32'(s2_cycle), m[68] & trap_invalid_en, m});
        end
        m_out_valid = s2_valid;
        s2_valid = s1_valid;
        s2_op = s1_op;
        s2_a = pick_operand(s1_a, s1_src_a, s1_late_a, fwd_data, m_prev);
        s2_b = pick_operand(s1_b, s1_src_b, s1_late_b, fwd_data, m_prev);
        s2_cycle = s1_cycle;
        s1_valid = in_valid;
        if (in_valid) begin
          s1_op = in_op;
          s1_a = in_a;
          s1_b = in_b;
          s1_src_a = in_src_a;
          s1_src_b = in_src_b;
          s1_late_a = in_late_a;
          s1_late_b = in_late_b;
          s1_cycle = cycle;
        end
      end
    end
    m_prev = fwd_data;
  end

  // hold the payload until the DUT takes it
  task automatic send_op(fpu_op_e op, fp_word_t a, fp_word_t b, int src_a, int src_b);
    in_valid <= 1'b1;
    in_op <= op;
    in_a <= a;
    in_b <= b;
    in_src_a <= SEL_W'(src_a);
    in_src_b <= SEL_W'(src_b);
    in_late_a <= 1'($random(seed));
    in_late_b <= 1'($random(seed));
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // mode 0 permute, 1 forwarding, 2 special compares, 3 random compares,
  // 4 random sink readiness
  task automatic run_test(string name, int mode);
    int       start_err;
    fpu_op_e  op;
    fp_word_t a;
    fp_word_t b;
    int       sel;
    start_err = errors;
    ready_random = (mode == 4);
    for (int i = 0; i < OPS; i++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      sel = {$random(seed)} % 4;
      op = fpu_op_e'({$random(seed)} % (mode == 0 ? 5 : 9));
      if (mode == 2 || mode == 3) begin
        op = fpu_op_e'(5 + {$random(seed)} % 4);
      end
      if (mode == 2) begin
        a = special_value({$random(seed)} % 12);
        b = special_value({$random(seed)} % 12);
      end else if (mode == 3 && sel < 2) begin
        b = (sel == 0) ? a : {~a[63], a[62:0]};
      end
      if (mode == 4 && sel == 0) begin
        @(posedge clk);
      end
      if (mode == 2 || mode == 3) begin
        send_op(op, a, b, 0, 0);
      end else begin
        send_op(op, a, b, {$random(seed)} % 5, {$random(seed)} % 5);
      end
    end
    repeat (2) @(posedge clk);
    while (exp_q.size() != 0 || s1_valid || s2_valid || m_out_valid) @(posedge clk);
    $display("test %s: %0d ops, %0d errors", name, OPS, errors - start_err);
  endtask

  initial begin
    rst <= 1'b1;
    in_valid <= 1'b0;
    in_op <= op_copy_a;
    in_a <= '0;
    in_b <= '0;
    in_src_a <= '0;
    in_src_b <= '0;
    in_late_a <= 1'b0;
    in_late_b <= 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("Error at %0t: after reset out_valid %b in_ready %b", $time, out_valid, in_ready);
      errors++;
    end
    $display("test reset: %0d errors", errors);
    run_test("permute", 0);
    run_test("forwarding", 1);
    run_test("special_compare", 2);
    run_test("random_compare", 3);
    run_test("backpressure", 4);
    $display("summary: %0d tests, %0d ops, %0d errors", NUM_TESTS + 1, NUM_TESTS * OPS, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(MAX_CYC * 10);
    $display("watchdog: the run did not finish within %0d cycles", MAX_CYC);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* all.f */
common/fpu_pkg.sv
fpu_execute/fp_compare.sv
fpu_execute/fpu_execute.sv
verilog/operand_bypass.sv
verilog/fpu_issue.sv
verilog/fpu_top.sv
tb/tb_fpu.sv

/* Makefile */
SIM      = verilator
TOP      = tb_fpu
FILELIST = all.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
	  echo "run passed"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
